// ==== design/rv_pkg.sv ====
// RV32I core shared definitions
// ISA widths, opcodes, instruction enums and the records passed between stages
`default_nettype none

package rv_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_idx_t;

    localparam word_t RESET_PC = 32'h8000_0000;

    // Major opcodes supported by this core
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;

    // Branch conditions in funct3
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    typedef enum logic [2:0] {
        TYPE_R,  // Register-register
        TYPE_I,  // Immediate ALU and JALR
        TYPE_U,  // LUI, AUIPC
        TYPE_J,  // JAL
        TYPE_B,  // Conditional branch
        TYPE_N   // Unsupported
    } inst_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    // Everything execute needs from one instruction
    typedef struct packed {
        logic [6:0] opcode;
        logic [2:0] funct3;
        reg_idx_t   rd;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        word_t      imm;
        inst_t      inst_type;
        alu_op_t    alu_op;
        logic       illegal;
    } decoded_t;

    // Record of one retired instruction
    typedef struct packed {
        word_t    pc;
        reg_idx_t rd;
        word_t    wdata;
        logic     we;       // Never set for x0
        logic     illegal;
    } retire_t;

endpackage

`default_nettype wire

// ==== design/rv_alu.sv ====
// Integer ALU with branch comparator
// Ten RV32I operations plus the six branch conditions on the same operands
`timescale 1ns/1ps
`default_nettype none

module rv_alu (
    input  rv_pkg::word_t    a,
    input  rv_pkg::word_t    b,
    input  rv_pkg::alu_op_t  op,
    input  logic [2:0]       funct3,
    output rv_pkg::word_t    result,
    output logic             branch_taken
);
    import rv_pkg::*;

    logic [4:0] shamt;
    logic       equal;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b[4:0];
    assign equal       = a == b;
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLL:  result = a << shamt;
            ALU_SLT:  result = {{(XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU: result = {{(XLEN-1){1'b0}}, lt_unsigned};
            ALU_XOR:  result = a ^ b;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = $signed(a) >>> shamt;  // Sign fill
            ALU_OR:   result = a | b;
            ALU_AND:  result = a & b;
            default:  result = a + b;
        endcase
    end

    always_comb begin
        case (funct3)
            F3_BEQ:  branch_taken = equal;
            F3_BNE:  branch_taken = !equal;
            F3_BLT:  branch_taken = lt_signed;
            F3_BGE:  branch_taken = !lt_signed;
            F3_BLTU: branch_taken = lt_unsigned;
            F3_BGEU: branch_taken = !lt_unsigned;
            default: branch_taken = 1'b0;  // Reserved encodings never branch
        endcase
    end

endmodule

`default_nettype wire

// ==== design/rv_decoder.sv ====
// Instruction decoder
// Splits out the fields, classifies the format and builds immediate and ALU op
`timescale 1ns/1ps
`default_nettype none

module rv_decoder (
    input  rv_pkg::word_t     inst,
    output rv_pkg::decoded_t  dec
);
    import rv_pkg::*;

    logic [6:0] opcode;
    logic [6:0] funct7;
    inst_t      inst_type;
    word_t      imm;
    alu_op_t    alu_op;

    assign opcode = inst[6:0];
    assign funct7 = inst[31:25];

    always_comb begin
        case (opcode)
            OP_REG:            inst_type = TYPE_R;
            OP_IMM, OP_JALR:   inst_type = TYPE_I;
            OP_LUI, OP_AUIPC:  inst_type = TYPE_U;
            OP_JAL:            inst_type = TYPE_J;
            OP_BRANCH:         inst_type = TYPE_B;
            default:           inst_type = TYPE_N;
        endcase
    end

    // Sign-extended immediates per format
    always_comb begin
        case (inst_type)
            TYPE_I:  imm = {{20{inst[31]}}, inst[31:20]};
            TYPE_U:  imm = {inst[31:12], 12'b0};
            TYPE_J:  imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            TYPE_B:  imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            default: imm = '0;
        endcase
    end

    always_comb begin
        alu_op = ALU_ADD;  // Address and U-type arithmetic
        if (opcode == OP_REG || opcode == OP_IMM) begin
            case (inst[14:12])
                3'b000: begin
                    // SUB exists only in the register form
                    if (opcode == OP_REG && funct7[5]) begin
                        alu_op = ALU_SUB;
                    end
                end
                3'b001:  alu_op = ALU_SLL;
                3'b010:  alu_op = ALU_SLT;
                3'b011:  alu_op = ALU_SLTU;
                3'b100:  alu_op = ALU_XOR;
                3'b101:  alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
                3'b110:  alu_op = ALU_OR;
                default: alu_op = ALU_AND;
            endcase
        end
    end

    assign dec = '{opcode:    opcode,
                   funct3:    inst[14:12],
                   rd:        inst[11:7],
                   rs1:       inst[19:15],
                   rs2:       inst[24:20],
                   imm:       imm,
                   inst_type: inst_type,
                   alu_op:    alu_op,
                   illegal:   inst_type == TYPE_N};

endmodule

`default_nettype wire

// ==== design/rv_regfile.sv ====
// General register file
// x1..x31 with x0 reading as zero, two read ports and one write port
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
    input  logic              clk,
    input  logic              reset,
    input  logic              we,
    input  rv_pkg::reg_idx_t  waddr,
    input  rv_pkg::word_t     wdata,
    input  rv_pkg::reg_idx_t  raddr1,
    input  rv_pkg::reg_idx_t  raddr2,
    output rv_pkg::word_t     rdata1,
    output rv_pkg::word_t     rdata2
);
    import rv_pkg::*;

    word_t regs [1:31];  // No storage behind x0

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// ==== design/rv_execute.sv ====
// Execute stage
// Operand selection, branch and jump resolution and writeback around the ALU
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
    input  logic              commit,
    input  rv_pkg::word_t     pc,
    input  rv_pkg::decoded_t  dec,
    input  rv_pkg::word_t     rs1_data,
    input  rv_pkg::word_t     rs2_data,
    output rv_pkg::word_t     next_pc,
    output rv_pkg::retire_t   result,
    output logic              rf_we,
    output rv_pkg::reg_idx_t  rf_waddr,
    output rv_pkg::word_t     rf_wdata
);
    import rv_pkg::*;

    word_t op_a;
    word_t op_b;
    word_t alu_result;
    word_t target;
    word_t pc_plus4;
    logic  branch_taken;
    logic  is_jalr;
    logic  is_jump;
    logic  wb_en;

    assign pc_plus4 = pc + 32'd4;
    assign is_jalr  = dec.opcode == OP_JALR;
    assign is_jump  = dec.inst_type == TYPE_J || is_jalr;

    always_comb begin
        case (dec.inst_type)
            TYPE_R, TYPE_B: begin  // Branches compare rs1 with rs2
                op_a = rs1_data;
                op_b = rs2_data;
            end
            TYPE_I: begin
                op_a = rs1_data;
                op_b = dec.imm;
            end
            TYPE_U: begin
                op_a = (dec.opcode == OP_LUI) ? '0 : pc;
                op_b = dec.imm;
            end
            default: begin
                op_a = pc;
                op_b = dec.imm;
            end
        endcase
    end

    rv_alu u_alu (
        .a            (op_a),
        .b            (op_b),
        .op           (dec.alu_op),
        .funct3       (dec.funct3),
        .result       (alu_result),
        .branch_taken (branch_taken)
    );

    // Jump and branch target adder
    rv_alu u_target (
        .a            (is_jalr ? rs1_data : pc),
        .b            (dec.imm),
        .op           (ALU_ADD),
        .funct3       (dec.funct3),
        .result       (target),
        .branch_taken ()
    );

    always_comb begin
        if (is_jalr) begin
            next_pc = {target[XLEN-1:1], 1'b0};
        end else if (dec.inst_type == TYPE_J) begin
            next_pc = target;
        end else if (dec.inst_type == TYPE_B && branch_taken) begin
            next_pc = target;
        end else begin
            next_pc = pc_plus4;  // Also for illegal opcodes
        end
    end

    assign wb_en    = !dec.illegal && dec.inst_type != TYPE_B && dec.rd != '0;
    assign rf_wdata = is_jump ? pc_plus4 : alu_result;
    assign rf_waddr = dec.rd;
    assign rf_we    = commit && wb_en;

    assign result = '{pc:      '0,  // Filled in by fetch
                      rd:      dec.rd,
                      wdata:   rf_wdata,
                      we:      wb_en,
                      illegal: dec.illegal};

endmodule

`default_nettype wire

// ==== design/rv_fetch.sv ====
// Fetch unit
// Holds the pc, issues one fetch at a time and registers the retire record
`timescale 1ns/1ps
`default_nettype none

module rv_fetch (
    input  logic             clk,
    input  logic             reset,
    input  logic             inst_valid,
    input  rv_pkg::word_t    next_pc,
    input  rv_pkg::retire_t  result,
    output logic             fetch_req,
    output rv_pkg::word_t    fetch_addr,
    output logic             retire_valid,
    output rv_pkg::retire_t  retire,
    output logic             commit
);
    import rv_pkg::*;

    word_t pc;
    logic  started;      // Low only until the boot fetch is issued
    logic  outstanding;  // A fetch is waiting for its instruction

    assign fetch_addr = pc;
    assign commit     = outstanding & inst_valid;  // Stray inst_valid is dropped

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc           <= RESET_PC;
            started      <= 1'b0;
            outstanding  <= 1'b0;
            fetch_req    <= 1'b0;
            retire_valid <= 1'b0;
        end else begin
            started      <= 1'b1;
            fetch_req    <= !started || commit;  // Boot fetch, then one per commit
            retire_valid <= commit;
            if (fetch_req) begin
                outstanding <= 1'b1;
            end else if (commit) begin
                outstanding <= 1'b0;
            end
            if (commit) begin
                pc <= next_pc;
            end
        end
    end

    // Retire payload, pc of the committed instruction added here
    always_ff @(posedge clk) begin
        if (commit) begin
            retire <= '{pc:      pc,
                        rd:      result.rd,
                        wdata:   result.wdata,
                        we:      result.we,
                        illegal: result.illegal};
        end
    end

endmodule

`default_nettype wire

// ==== design/rv_core.sv ====
// RV32I integer core top level
// Fetch, decode, execute and register file with one instruction in flight
`timescale 1ns/1ps
`default_nettype none

module rv_core (
    input  logic             clk,
    input  logic             reset,
    input  logic             inst_valid,
    input  rv_pkg::word_t    inst,
    output logic             fetch_req,
    output rv_pkg::word_t    fetch_addr,
    output logic             retire_valid,
    output rv_pkg::retire_t  retire
);
    import rv_pkg::*;

    logic     commit;
    word_t    next_pc;
    retire_t  result;
    decoded_t dec;
    word_t    rs1_data;
    word_t    rs2_data;
    logic     rf_we;
    reg_idx_t rf_waddr;
    word_t    rf_wdata;

    rv_fetch u_fetch (
        .clk          (clk),
        .reset        (reset),
        .inst_valid   (inst_valid),
        .next_pc      (next_pc),
        .result       (result),
        .fetch_req    (fetch_req),
        .fetch_addr   (fetch_addr),
        .retire_valid (retire_valid),
        .retire       (retire),
        .commit       (commit)
    );

    rv_decoder u_decoder (
        .inst (inst),
        .dec  (dec)
    );

    rv_regfile u_regfile (
        .clk    (clk),
        .reset  (reset),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata),
        .raddr1 (dec.rs1),
        .raddr2 (dec.rs2),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    // Fetch address is the pc of the instruction being executed
    rv_execute u_execute (
        .commit   (commit),
        .pc       (fetch_addr),
        .dec      (dec),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .next_pc  (next_pc),
        .result   (result),
        .rf_we    (rf_we),
        .rf_waddr (rf_waddr),
        .rf_wdata (rf_wdata)
    );

endmodule

`default_nettype wire

// ==== tb/rv_core_props.sv ====
// Strobe timing properties of the RV32I core
// Bound into rv_core next to the testbench
`timescale 1ns/1ps
`default_nettype none

module rv_core_props (
    input  logic             clk,
    input  logic             reset,
    input  logic             fetch_req,
    input  logic             inst_valid,
    input  logic             retire_valid,
    input  rv_pkg::retire_t  retire
);

    logic pending;  // Fetch issued, instruction not yet accepted

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pending <= 1'b0;
        end else if (fetch_req) begin
            pending <= 1'b1;
        end else if (inst_valid) begin
            pending <= 1'b0;
        end
    end

    a_retire_follows: assert property (@(posedge clk) disable iff (reset)
        pending && inst_valid |=> retire_valid)
        else $error("retire_valid missing one cycle after an accepted instruction");

    a_retire_cause: assert property (@(posedge clk) disable iff (reset)
        retire_valid |-> $past(pending && inst_valid))
        else $error("retire_valid without an accepted instruction the cycle before");

    a_no_req_pending: assert property (@(posedge clk) disable iff (reset)
        pending |-> !fetch_req)
        else $error("fetch_req raised while a fetch was outstanding");

    a_x0_no_we: assert property (@(posedge clk) disable iff (reset)
        retire_valid && retire.rd == '0 |-> !retire.we)
        else $error("retire to x0 with the write enable set");

endmodule

bind rv_core rv_core_props u_props (
    .clk          (clk),
    .reset        (reset),
    .fetch_req    (fetch_req),
    .inst_valid   (inst_valid),
    .retire_valid (retire_valid),
    .retire       (retire)
);

`default_nettype wire

// ==== tb/rv_core_tb.sv ====
// Testbench for the RV32I core
// Random instruction stream with random latency, checked against a reference model
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;
    import rv_pkg::*;

    localparam int NUM_INSTS = 2000;
    localparam int TIMEOUT   = NUM_INSTS * 5 + 100;
    localparam int NUM_TESTS = 6;
    localparam int T_RESET   = 0;
    localparam int T_ALU     = 1;
    localparam int T_BJ      = 2;
    localparam int T_X0      = 3;
    localparam int T_ILL     = 4;
    localparam int T_PC      = 5;

    logic    clk;
    logic    reset;
    logic    inst_valid;
    word_t   inst;
    logic    fetch_req;
    word_t   fetch_addr;
    logic    retire_valid;
    retire_t retire;

    string test_name [NUM_TESTS] = '{"reset_fetch", "alu_ops", "branch_jump",
                                     "x0_zero", "illegal", "retire_pc"};
    int    checks [NUM_TESTS];
    int    errors [NUM_TESTS];
    int    cycles = 0;

    logic [31:0] rng;
    word_t       model_regs [32];  // x0 is never written
    word_t       model_pc;
    word_t       exp_wdata;
    word_t       exp_npc;
    logic        exp_wr;           // Instruction class writes rd
    logic        exp_ill;

    rv_core uut (
        .clk          (clk),
        .reset        (reset),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .fetch_req    (fetch_req),
        .fetch_addr   (fetch_addr),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("timeout: the core stopped answering after %0d cycles", cycles);
            $display("tests failed");
            $finish;
        end
    end

    // LCG, upper half folded into the weak low bits
    function automatic logic [31:0] rand32();
        rng = rng * 32'd1664525 + 32'd1013904223;
        return {rng[31:16], rng[31:16] ^ rng[15:0]};
    endfunction

    function automatic word_t gen_inst();
        int         pick;
        logic [2:0] f3;
        reg_idx_t   rd;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        word_t      r;
        logic [6:0] bad_op;
        pick = int'(rand32() % 100);
        f3   = 3'(rand32() >> 7);
        rd   = 5'(rand32() >> 9);
        rs1  = 5'(rand32() >> 9);
        rs2  = 5'(rand32() >> 9);
        r    = rand32();
        if (pick >= 90) begin
            rd = '0;  // ALU ops aimed at x0
        end else if (pick < 40 && rd == '0) begin
            rd = 5'd1;
        end
        if (pick < 20 || (pick >= 90 && pick < 95)) begin
            return {1'b0, r[30] && (f3 == 3'd0 || f3 == 3'd5), 5'b0, rs2, rs1, f3, rd, OP_REG};
        end else if (pick < 40 || pick >= 95) begin
            if (f3 == 3'd1) begin
                r[31:25] = '0;  // SLLI has no funct7 variants
            end else if (f3 == 3'd5) begin
                r[31:25] = {1'b0, r[30], 5'b0};
            end
            return {r[31:20], rs1, f3, rd, OP_IMM};
        end else if (pick < 50) begin
            return {r[31:12], rd, r[0] ? OP_LUI : OP_AUIPC};
        end else if (pick < 75) begin
            if (f3 == 3'd2 || f3 == 3'd3) begin
                f3 = f3 ^ 3'b100;  // Skip the reserved conditions
            end
            return {r[31:25], rs2, rs1, f3, r[11:7], OP_BRANCH};
        end else if (pick < 85) begin
            return r[0] ? {r[31:12], rd, OP_JAL} : {r[31:20], rs1, 3'b000, rd, OP_JALR};
        end
        case (r[1:0])
            2'd0:    bad_op = 7'b0000011;  // Load
            2'd1:    bad_op = 7'b0100011;  // Store
            2'd2:    bad_op = 7'b1110011;  // System
            default: bad_op = 7'b0001111;  // Fence
        endcase
        return {r[31:7], bad_op};
    endfunction

    function automatic word_t alu_model(input logic [2:0] f3, input logic alt,
                                        input word_t a, input word_t b);
        logic [4:0] sh;
        sh = b[4:0];
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << sh;
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) begin
                    return $signed(a) >>> sh;
                end
                return a >> sh;
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // Executes one instruction on the model state
    task automatic run_model(input word_t ins);
        logic [2:0] f3;
        reg_idx_t   rd;
        word_t      a;
        word_t      b;
        word_t      imm_i;
        logic       taken;
        f3        = ins[14:12];
        rd        = ins[11:7];
        a         = model_regs[ins[19:15]];
        b         = model_regs[ins[24:20]];
        imm_i     = {{20{ins[31]}}, ins[31:20]};
        exp_npc   = model_pc + 32'd4;
        exp_wdata = '0;
        exp_wr    = 1'b1;
        exp_ill   = 1'b0;
        taken     = 1'b0;
        case (ins[6:0])
            OP_REG:   exp_wdata = alu_model(f3, ins[30], a, b);
            OP_IMM:   exp_wdata = alu_model(f3, ins[30] && f3 == 3'd5, a, imm_i);
            OP_LUI:   exp_wdata = {ins[31:12], 12'b0};
            OP_AUIPC: exp_wdata = model_pc + {ins[31:12], 12'b0};
            OP_JAL: begin
                exp_wdata = model_pc + 32'd4;
                exp_npc   = model_pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            OP_JALR: begin
                exp_wdata = model_pc + 32'd4;
                exp_npc   = (a + imm_i) & ~32'd1;
            end
            OP_BRANCH: begin
                exp_wr = 1'b0;
                case (f3)
                    F3_BEQ:  taken = a == b;
                    F3_BNE:  taken = a != b;
                    F3_BLT:  taken = $signed(a) < $signed(b);
                    F3_BGE:  taken = $signed(a) >= $signed(b);
                    F3_BLTU: taken = a < b;
                    F3_BGEU: taken = a >= b;
                    default: taken = 1'b0;
                endcase
                if (taken) begin
                    exp_npc = model_pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                end
            end
            default: begin
                exp_wr  = 1'b0;
                exp_ill = 1'b1;
            end
        endcase
        if (exp_wr && rd != '0) begin
            model_regs[rd] = exp_wdata;
        end
    endtask

    task automatic check(input int t, input word_t exp, input word_t act, input string what);
        checks[t]++;
        if (exp !== act) begin
            errors[t]++;
            $display("MISMATCH %s %s: expected %h actual %h", test_name[t], what, exp, act);
        end
    endtask

    initial begin
        word_t addr;
        word_t word;
        int    delay;
        int    t_inst;
        int    t_next;
        int    total_chk;
        int    total_err;
        reset      = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        rng        = 32'h4387_ff41;
        model_pc   = RESET_PC;
        total_chk  = 0;
        total_err  = 0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        for (int t = 0; t < NUM_TESTS; t++) begin
            checks[t] = 0;
            errors[t] = 0;
        end

        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        while (!fetch_req) begin
            check(T_RESET, 32'd0, 32'(retire_valid), "retire_valid");
            @(posedge clk);
        end
        check(T_RESET, RESET_PC, fetch_addr, "fetch_addr");

        for (int n = 0; n < NUM_INSTS; n++) begin
            addr  = fetch_addr;  // Sampled in the fetch_req cycle
            word  = gen_inst();
            delay = 1 + int'(rand32() % 3);
            repeat (delay - 1) begin
                @(posedge clk);
                if (n == 0) begin
                    check(T_RESET, 32'd0, 32'(retire_valid), "retire_valid");
                end
            end
            inst_valid <= 1'b1;
            inst       <= word;
            @(posedge clk);
            inst_valid <= 1'b0;
            inst       <= rand32();  // Junk while idle
            run_model(word);
            @(posedge clk);
            while (!retire_valid) @(posedge clk);

            t_next = exp_ill ? T_ILL : T_BJ;
            if (exp_ill) begin
                t_inst = T_ILL;
            end else if (exp_wr && word[11:7] == '0) begin
                t_inst = T_X0;
            end else if (word[6:0] == OP_BRANCH || word[6:0] == OP_JAL
                         || word[6:0] == OP_JALR) begin
                t_inst = T_BJ;
            end else begin
                t_inst = T_ALU;
            end
            check(T_PC, addr, retire.pc, "retire.pc");
            check(t_inst, 32'(exp_ill), 32'(retire.illegal), "retire.illegal");
            check(t_inst, 32'(exp_wr && word[11:7] != '0), 32'(retire.we), "retire.we");
            if (exp_wr) begin
                check(t_inst, 32'(word[11:7]), 32'(retire.rd), "retire.rd");
                check(t_inst, exp_wdata, retire.wdata, "retire.wdata");
            end
            check(t_next, 32'd1, 32'(fetch_req), "fetch_req");
            check(t_next, exp_npc, fetch_addr, "fetch_addr");
            model_pc = exp_npc;
        end

        for (int t = 0; t < NUM_TESTS; t++) begin
            $display("%-12s %0d checks, %0d errors", test_name[t], checks[t], errors[t]);
            total_chk += checks[t];
            total_err += errors[t];
        end
        $display("total %0d checks, %0d errors", total_chk, total_err);
        if (total_err == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
design/rv_pkg.sv
design/rv_alu.sv
design/rv_decoder.sv
design/rv_regfile.sv
design/rv_execute.sv
design/rv_fetch.sv
design/rv_core.sv
tb/rv_core_props.sv
tb/rv_core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= rv_core_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= all tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
